/* source/irq_cfg_pkg.sv */
// interrupt controller configuration
// line and group counts, port widths and the fixed line maps
package irq_cfg_pkg;

	localparam int irq_lines  = 32;  // request lines, 0 is highest
	localparam int irq_groups = 10;  // mask bits
	localparam int irq_grp_w  = 4;   // group index, one slot past the mask bits
	localparam int irq_vec_w  = 5;   // vector line number
	localparam int irq_data_w = 16;  // command data word

	// mask group of each line
	// group irq_groups means no mask bit at all
	localparam logic [irq_grp_w-1:0] irq_group_of [irq_lines] = '{
		irq_grp_w'(irq_groups),                 // 0 power fail, never masked
		4'd0, 4'd1, 4'd2, 4'd3,                 // 1-4 own bits
		4'd4, 4'd4, 4'd4, 4'd4,                 // 5-8
		4'd4, 4'd4, 4'd4,                       // 9-11
		4'd5, 4'd5,                             // 12-13 channel
		4'd6, 4'd6,                             // 14-15 channel
		4'd7, 4'd7, 4'd7, 4'd7, 4'd7, 4'd7,     // 16-21 channel
		4'd8, 4'd8, 4'd8, 4'd8, 4'd8, 4'd8,     // 22-27 channel
		4'd9, 4'd9, 4'd9, 4'd9                  // 28-31 low group
	};

	// data bit to line for software set and clear
	// channel lines 12-27 have no data bit
	localparam logic [irq_vec_w-1:0] irq_sw_line [irq_data_w] = '{
		5'd0, 5'd1, 5'd2, 5'd3,
		5'd4, 5'd5, 5'd6, 5'd7,
		5'd8, 5'd9, 5'd10, 5'd11,
		5'd28, 5'd29, 5'd30, 5'd31  // bits 12-15 skip the channels
	};

endpackage

/* source/irq_bus_pkg.sv */
// interrupt controller CPU port types
// command word with its two data views, and the vector word
package irq_bus_pkg;

	// command codes
	typedef enum logic [1:0] {
		op_set_mask,  // load mask register
		op_set_req,   // software request set
		op_clr_req,   // software request clear
		op_eoi        // end of interrupt
	} irq_op_e;

	// mask view of the data word, mask bits on top
	typedef struct packed {
		logic [irq_cfg_pkg::irq_groups-1:0] bits;
		logic [irq_cfg_pkg::irq_data_w-irq_cfg_pkg::irq_groups-1:0] pad;  // ignored
	} irq_mask_view_t;

	// data word, read as a line pattern or as a mask
	typedef union packed {
		logic [irq_cfg_pkg::irq_data_w-1:0] pattern;  // via irq_sw_line
		irq_mask_view_t mask;
	} irq_data_u;

	// one command, 18 bits
	typedef struct packed {
		irq_op_e op;
		irq_data_u data;
	} irq_cmd_t;

	// winning line and its mask group, 9 bits
	typedef struct packed {
		logic [irq_cfg_pkg::irq_vec_w-1:0] line;
		logic [irq_cfg_pkg::irq_grp_w-1:0] group;
	} irq_vec_t;

endpackage

/* source/irq_cell.sv */
// interrupt line cell
// request and in-service bits of one line plus its priority chain link
`timescale 1ns/10ps

module irq_cell (
	input  logic clk,
	input  logic arst_n,
	input  logic set,      // edge or software set
	input  logic clr,      // software clear
	input  logic en,       // mask group open
	input  logic take,     // vector accepted for this line
	input  logic done,     // end of interrupt for this line
	input  logic free_in,  // nothing above is busy
	output logic free_out,
	output logic req,
	output logic in_svc,
	output logic grant
);

	logic req_en;

	assign req_en = req & en;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req <= 1'b0;
			in_svc <= 1'b0;
		end else begin
			if (take) begin
				req <= 1'b0;  // taken request wins over a new edge
			end else begin
				req <= set | (req & ~clr);  // set beats clear
			end
			in_svc <= take | (in_svc & ~done);
		end
	end

	// line in service also blocks its own new request
	assign grant = req_en & free_in & ~in_svc;
	// busy or pending line blocks everything below
	assign free_out = free_in & ~in_svc & ~req_en;

endmodule

/* source/irq_source_collect.sv */
// interrupt source collector
// synchronizes the async request lines, buffers one CPU command,
// holds the mask register and fans set, clear and enable out per line
`timescale 1ns/10ps

module irq_source_collect (
	input  logic clk,
	input  logic arst_n,
	input  logic [irq_cfg_pkg::irq_lines-1:0] irq_in,  // async, active high
	input  logic cmd_valid,
	input  irq_bus_pkg::irq_cmd_t cmd,
	output logic cmd_ready,
	output logic [irq_cfg_pkg::irq_lines-1:0] line_set,
	output logic [irq_cfg_pkg::irq_lines-1:0] line_clr,
	output logic [irq_cfg_pkg::irq_lines-1:0] line_en,
	output logic eoi,
	output logic [irq_cfg_pkg::irq_groups-1:0] mask
);

	logic [irq_cfg_pkg::irq_lines-1:0] irq_s1;    // first sync stage
	logic [irq_cfg_pkg::irq_lines-1:0] irq_s2;    // second sync stage
	logic [irq_cfg_pkg::irq_lines-1:0] irq_prev;  // edge flop
	logic [irq_cfg_pkg::irq_lines-1:0] edge_set;
	irq_bus_pkg::irq_cmd_t cmd_buf;
	logic buf_vld;
	logic [irq_cfg_pkg::irq_lines-1:0] sw_lines;
	logic [irq_cfg_pkg::irq_lines-1:0] sw_set_q;
	logic [irq_cfg_pkg::irq_lines-1:0] sw_clr_q;
	logic mask_we_q;
	logic [irq_cfg_pkg::irq_groups-1:0] mask_d_q;
	logic [irq_cfg_pkg::irq_groups:0] mask_ext;

	// async lines, 2 sync flops then edge flop
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			irq_s1 <= '0;
			irq_s2 <= '0;
			irq_prev <= '0;
		end else begin
			irq_s1 <= irq_in;
			irq_s2 <= irq_s1;
			irq_prev <= irq_s2;
		end
	end
	assign edge_set = irq_s2 & ~irq_prev;  // rising edges only

	// one-deep command buffer, busy for the cycle after accept
	assign cmd_ready = !buf_vld;
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			buf_vld <= 1'b0;
		end else begin
			buf_vld <= cmd_valid && cmd_ready;
		end
	end
	always_ff @(posedge clk) begin
		if (cmd_valid && cmd_ready) begin
			cmd_buf <= cmd;
		end
	end

	// pattern view spread onto the settable lines
	always_comb begin
		sw_lines = '0;
		for (int i = 0; i < irq_cfg_pkg::irq_data_w; i++) begin
			sw_lines[irq_cfg_pkg::irq_sw_line[i]] = cmd_buf.data.pattern[i];
		end
	end

	// decode stage, all outputs are one-cycle pulses
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sw_set_q <= '0;
			sw_clr_q <= '0;
			mask_we_q <= 1'b0;
			eoi <= 1'b0;
		end else begin
			sw_set_q <= '0;
			sw_clr_q <= '0;
			mask_we_q <= 1'b0;
			eoi <= 1'b0;
			if (buf_vld) begin
				case (cmd_buf.op)
					irq_bus_pkg::op_set_mask: mask_we_q <= 1'b1;
					irq_bus_pkg::op_set_req:  sw_set_q <= sw_lines;
					irq_bus_pkg::op_clr_req:  sw_clr_q <= sw_lines;
					irq_bus_pkg::op_eoi:      eoi <= 1'b1;
					default: ;
				endcase
			end
		end
	end
	always_ff @(posedge clk) begin
		if (buf_vld) begin
			mask_d_q <= cmd_buf.data.mask.bits;  // mask view
		end
	end

	// mask register, everything masked after reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mask <= '0;
		end else if (mask_we_q) begin
			mask <= mask_d_q;
		end
	end

	assign line_set = edge_set | sw_set_q;  // hw and sw sets merge
	assign line_clr = sw_clr_q;

	// per-line enable, extra top slot for the unmaskable line
	assign mask_ext = {1'b1, mask};
	always_comb begin
		for (int k = 0; k < irq_cfg_pkg::irq_lines; k++) begin
			line_en[k] = mask_ext[irq_cfg_pkg::irq_group_of[k]];
		end
	end

endmodule

/* source/irq_vector_encode.sv */
// interrupt vector encoder
// turns the one-hot grant into a held vector, issues take at the
// vector handshake and done for the lowest in-service line on eoi
`timescale 1ns/10ps

module irq_vector_encode (
	input  logic clk,
	input  logic arst_n,
	input  logic [irq_cfg_pkg::irq_lines-1:0] grant,   // one-hot or zero
	input  logic [irq_cfg_pkg::irq_lines-1:0] in_svc,
	input  logic eoi,
	output logic vec_valid,
	output irq_bus_pkg::irq_vec_t vec,
	input  logic vec_ready,
	output logic [irq_cfg_pkg::irq_lines-1:0] take,
	output logic [irq_cfg_pkg::irq_lines-1:0] done
);

	logic [irq_cfg_pkg::irq_vec_w-1:0] win_line;
	logic eoi_d;

	// one-hot to line number
	always_comb begin
		win_line = '0;
		for (int k = 0; k < irq_cfg_pkg::irq_lines; k++) begin
			if (grant[k]) begin
				win_line = k[irq_cfg_pkg::irq_vec_w-1:0];
			end
		end
	end

	// port state
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vec_valid <= 1'b0;
			eoi_d <= 1'b0;
		end else begin
			if (!vec_valid) begin
				vec_valid <= |grant;  // raise on any winner
			end else if (vec_ready) begin
				vec_valid <= 1'b0;  // one idle cycle after handshake
			end
			eoi_d <= eoi;
		end
	end

	// vector loads only while idle and freezes under back-pressure
	always_ff @(posedge clk) begin
		if (!vec_valid) begin
			vec.line <= win_line;
			vec.group <= irq_cfg_pkg::irq_group_of[win_line];
		end
	end

	// take the held line at the handshake edge
	always_comb begin
		take = '0;
		if (vec_valid && vec_ready) begin
			take[vec.line] = 1'b1;
		end
	end

	// lowest set in_svc bit by x & -x
	assign done = eoi_d ? (in_svc & -in_svc) : '0;

endmodule

/* source/irq_controller.sv */
// vectored interrupt controller top
// source collector, 32 line cells on a priority chain, vector encoder
`timescale 1ns/10ps

module irq_controller (
	input  logic clk,
	input  logic arst_n,
	input  logic [irq_cfg_pkg::irq_lines-1:0] irq_in,
	input  logic cmd_valid,
	input  irq_bus_pkg::irq_cmd_t cmd,
	output logic cmd_ready,
	output logic vec_valid,
	output irq_bus_pkg::irq_vec_t vec,
	input  logic vec_ready,
	output logic irq_pending,
	output logic [irq_cfg_pkg::irq_lines-1:0] req_status,
	output logic [irq_cfg_pkg::irq_lines-1:0] svc_status,
	output logic [irq_cfg_pkg::irq_groups-1:0] mask
);

	logic [irq_cfg_pkg::irq_lines-1:0] line_set;
	logic [irq_cfg_pkg::irq_lines-1:0] line_clr;
	logic [irq_cfg_pkg::irq_lines-1:0] line_en;
	logic [irq_cfg_pkg::irq_lines-1:0] grant;
	logic [irq_cfg_pkg::irq_lines-1:0] take;
	logic [irq_cfg_pkg::irq_lines-1:0] done;
	logic [irq_cfg_pkg::irq_lines:0] prio_free;  // top bit is the chain end
	logic eoi;

	irq_source_collect i_source_collect (
		.clk       (clk),
		.arst_n    (arst_n),
		.irq_in    (irq_in),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_ready (cmd_ready),
		.line_set  (line_set),
		.line_clr  (line_clr),
		.line_en   (line_en),
		.eoi       (eoi),
		.mask      (mask)
	);

	assign prio_free[0] = 1'b1;  // nothing above line 0

	for (genvar k = 0; k < irq_cfg_pkg::irq_lines; k++) begin : g_cell
		irq_cell i_cell (
			.clk      (clk),
			.arst_n   (arst_n),
			.set      (line_set[k]),
			.clr      (line_clr[k]),
			.en       (line_en[k]),
			.take     (take[k]),
			.done     (done[k]),
			.free_in  (prio_free[k]),
			.free_out (prio_free[k+1]),
			.req      (req_status[k]),
			.in_svc   (svc_status[k]),
			.grant    (grant[k])
		);
	end

	irq_vector_encode i_vector_encode (
		.clk       (clk),
		.arst_n    (arst_n),
		.grant     (grant),
		.in_svc    (svc_status),
		.eoi       (eoi),
		.vec_valid (vec_valid),
		.vec       (vec),
		.vec_ready (vec_ready),
		.take      (take),
		.done      (done)
	);

	assign irq_pending = |grant;  // some line can win now

endmodule

/* verification/irq_controller_assert.sv */
// interrupt controller checker
// concurrent assertions on the CPU ports and line status, bound to the top
`timescale 1ns/10ps

module irq_controller_assert (
	input logic clk,
	input logic arst_n,
	input logic [irq_cfg_pkg::irq_lines-1:0] irq_in,
	input logic cmd_valid,
	input irq_bus_pkg::irq_cmd_t cmd,
	input logic cmd_ready,
	input logic vec_valid,
	input irq_bus_pkg::irq_vec_t vec,
	input logic vec_ready,
	input logic irq_pending,
	input logic [irq_cfg_pkg::irq_lines-1:0] req_status,
	input logic [irq_cfg_pkg::irq_lines-1:0] svc_status,
	input logic [irq_cfg_pkg::irq_groups-1:0] mask
);

	logic acc;         // command accepted at this edge
	logic [31:0] take_oh;   // line taken at this edge
	logic [31:0] cmd_lines; // lines named by the pattern view
	logic [31:0] svc_low;   // lowest in-service bit
	logic [4:0] exp_line;
	logic exp_found;
	logic blocked;

	assign acc = cmd_valid && cmd_ready;
	assign take_oh = (vec_valid && vec_ready) ? (32'd1 << vec.line) : '0;

	always_comb begin
		cmd_lines = '0;
		for (int i = 0; i < irq_cfg_pkg::irq_data_w; i++) begin
			cmd_lines[irq_cfg_pkg::irq_sw_line[i]] = cmd.data.pattern[i];
		end
	end

	// expected winner, scan from line 0 and stop at the first busy line
	always_comb begin
		exp_found = 1'b0;
		exp_line = '0;
		blocked = 1'b0;
		for (int k = 0; k < irq_cfg_pkg::irq_lines; k++) begin
			if (svc_status[k]) begin
				blocked = 1'b1;
			end
			if (!blocked && !exp_found && req_status[k] &&
				(k == 0 || mask[irq_cfg_pkg::irq_group_of[k]])) begin
				exp_found = 1'b1;
				exp_line = 5'(k);
			end
		end
	end

	always_comb begin
		svc_low = '0;
		for (int k = irq_cfg_pkg::irq_lines - 1; k >= 0; k--) begin
			if (svc_status[k]) begin
				svc_low = 32'd1 << k;
			end
		end
	end

	// edge seen at the input, req set at the third edge after
	a_edge_sets_req: assert property (@(posedge clk) disable iff (!arst_n)
		$past(arst_n, 3) |->
		($past(irq_in, 3) & ~$past(irq_in, 4) & ~$past(take_oh) & ~req_status) == '0)
		else $error("MISMATCH %0t: irq_in edge did not set req_status", $time);

	a_mask_write: assert property (@(posedge clk) disable iff (!arst_n)
		$past(acc && cmd.op == irq_bus_pkg::op_set_mask, 3) |->
		mask == $past(cmd.data.mask.bits, 3))
		else $error("MISMATCH %0t: mask does not match written value", $time);

	a_sw_set: assert property (@(posedge clk) disable iff (!arst_n)
		$past(acc && cmd.op == irq_bus_pkg::op_set_req, 3) |->
		($past(cmd_lines, 3) & ~$past(take_oh) & ~req_status) == '0)
		else $error("MISMATCH %0t: software set missing in req_status", $time);

	// an edge set at the same edge beats the clear
	a_sw_clr: assert property (@(posedge clk) disable iff (!arst_n)
		$past(acc && cmd.op == irq_bus_pkg::op_clr_req, 3) |->
		($past(cmd_lines, 3) & ~($past(irq_in, 3) & ~$past(irq_in, 4)) & req_status) == '0)
		else $error("MISMATCH %0t: software clear left req_status set", $time);

	a_cmd_busy: assert property (@(posedge clk) disable iff (!arst_n)
		$past(acc) |-> !cmd_ready)
		else $error("MISMATCH %0t: cmd_ready high right after accept", $time);

	a_vec_winner: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(vec_valid) |-> $past(exp_found) && vec.line == $past(exp_line) &&
		vec.group == irq_cfg_pkg::irq_group_of[vec.line])
		else $error("MISMATCH %0t: vector line %0d is not the winner", $time, vec.line);

	a_vec_hold: assert property (@(posedge clk) disable iff (!arst_n)
		$past(vec_valid && !vec_ready) |-> vec_valid && vec == $past(vec))
		else $error("MISMATCH %0t: vector changed under back-pressure", $time);

	a_vec_take: assert property (@(posedge clk) disable iff (!arst_n)
		$past(vec_valid && vec_ready) |-> !vec_valid &&
		($past(take_oh) & svc_status) != '0 && ($past(take_oh) & req_status) == '0)
		else $error("MISMATCH %0t: taken line not moved into service", $time);

	// eoi applied at the third edge after accept
	a_eoi: assert property (@(posedge clk) disable iff (!arst_n)
		$past(acc && cmd.op == irq_bus_pkg::op_eoi, 4) |->
		svc_status == (($past(svc_status) & ~$past(svc_low)) | $past(take_oh)))
		else $error("MISMATCH %0t: eoi did not clear the lowest in-service line", $time);

	a_no_spurious: assert property (@(posedge clk) disable iff (!arst_n)
		!$past(vec_valid) && !$past(irq_pending) |-> !vec_valid)
		else $error("MISMATCH %0t: vec_valid raised with nothing pending", $time);

	a_reset_idle: assert property (@(posedge clk) !arst_n |-> !vec_valid)
		else $error("MISMATCH %0t: vec_valid high during reset", $time);

endmodule

bind irq_controller irq_controller_assert i_irq_controller_assert (.*);

/* verification/tb_irq_controller.sv */
// interrupt controller testbench
// directed phases per command op, then random line edges, commands and back-pressure
`timescale 1ns/10ps

module tb_irq_controller;

	localparam int n_reset    = 16;
	localparam int n_directed = 400;  // bound on the directed phases
	localparam int n_random   = 4000;
	localparam int hs_limit   = 64;   // cycles allowed per vector

	logic clk = 1'b0;
	logic arst_n = 1'b1;
	logic [31:0] irq_in = '0;
	logic cmd_valid = 1'b0;
	irq_bus_pkg::irq_cmd_t cmd = '0;
	logic vec_ready = 1'b0;
	logic cmd_ready;
	logic vec_valid;
	irq_bus_pkg::irq_vec_t vec;
	logic irq_pending;
	logic [31:0] req_status;
	logic [31:0] svc_status;
	logic [9:0] mask;
	int seed = 25889;
	bit passed = 1'b0;
	bit fail_shown = 1'b0;

	irq_controller i_irq_controller (
		.clk         (clk),
		.arst_n      (arst_n),
		.irq_in      (irq_in),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.cmd_ready   (cmd_ready),
		.vec_valid   (vec_valid),
		.vec         (vec),
		.vec_ready   (vec_ready),
		.irq_pending (irq_pending),
		.req_status  (req_status),
		.svc_status  (svc_status),
		.mask        (mask)
	);

	always #5 clk = ~clk;  // 10 ns

	task automatic step();
		@(posedge clk);
		#1;  // drive point
	endtask

	// hold valid until the collector accepts
	task automatic send_cmd(input irq_bus_pkg::irq_op_e op, input logic [15:0] data);
		logic taken;
		cmd_valid = 1'b1;
		cmd.op = op;
		cmd.data.pattern = data;
		do begin
			taken = cmd_ready;  // registered, stable until the edge
			step();
		end while (!taken);
		cmd_valid = 1'b0;
	endtask

	// one vector handshake, then end of interrupt
	task automatic serve();
		int n;
		n = 0;
		while (!(vec_valid && vec_ready)) begin
			step();
			n++;
			if (n > hs_limit) begin
				fail_shown = 1'b1;
				$display("TESTS FAILED");
				$fatal(1, "no vector handshake within %0d cycles", hs_limit);
			end
		end
		step();
		send_cmd(irq_bus_pkg::op_eoi, 16'h0000);
	endtask

	initial begin
		logic [31:0] r;
		bit taken;
		taken = 1'b0;
		#1;
		arst_n = 1'b0;
		repeat (n_reset) @(posedge clk);
		#1;
		arst_n = 1'b1;
		step();
		vec_ready = 1'b1;
		send_cmd(irq_bus_pkg::op_set_mask, 16'hffc0);  // all groups open
		send_cmd(irq_bus_pkg::op_set_req, 16'h0006);   // lines 1 and 2
		serve();
		serve();
		// 28 reaches the port, 28 and 29 cleared behind it
		vec_ready = 1'b0;
		send_cmd(irq_bus_pkg::op_set_req, 16'hf000);
		send_cmd(irq_bus_pkg::op_clr_req, 16'h3000);
		repeat (4) step();
		vec_ready = 1'b1;
		serve();
		serve();
		serve();
		irq_in[0] = 1'b1;   // unmaskable line
		irq_in[20] = 1'b1;  // channel line
		serve();
		serve();
		irq_in = '0;
		send_cmd(irq_bus_pkg::op_set_mask, 16'h0000);
		send_cmd(irq_bus_pkg::op_set_req, 16'h0002);
		repeat (8) step();  // line 1 masked, no vector
		send_cmd(irq_bus_pkg::op_set_mask, 16'h0040);  // group 0 only
		serve();
		repeat (n_random) begin
			irq_in = irq_in ^ ($random(seed) & $random(seed) & $random(seed) &
				$random(seed) & $random(seed));
			vec_ready = ($random(seed) & 3) != 0;
			if (!cmd_valid || taken) begin
				r = $random(seed);
				cmd_valid = r[31:30] == 2'b00;
				cmd.op = irq_bus_pkg::irq_op_e'(r[17:16]);
				cmd.data.pattern = r[15:0];
			end
			taken = cmd_valid && cmd_ready;
			step();
		end
		cmd_valid = 1'b0;
		irq_in = '0;
		repeat (20) step();
		passed = 1'b1;
		$display("TESTS PASSED");
		$finish;
	end

	// watchdog, twice the stimulus length
	initial begin
		#((n_reset + n_directed + n_random) * 2 * 10);
		fail_shown = 1'b1;
		$display("TESTS FAILED");
		$fatal(1, "watchdog timeout, stimulus did not finish");
	end

	final begin
		if (!passed && !fail_shown) begin
			$display("TESTS FAILED");
		end
	end

endmodule

/* src.f */
source/irq_cfg_pkg.sv
source/irq_bus_pkg.sv
source/irq_cell.sv
source/irq_source_collect.sv
source/irq_vector_encode.sv
source/irq_controller.sv
verification/irq_controller_assert.sv
verification/tb_irq_controller.sv

/* run.sh */
#!/bin/sh
# build and run the interrupt controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f src.f --top-module tb_irq_controller -o tb_sim
out=$(./obj_dir/tb_sim 2>&1 || true)
echo "$out"
echo "$out" | grep -q "TESTS PASSED"
